//--- Makefile
# Verilator build and run for the CPU shell testbench

VERILATOR ?= verilator
TOP       ?= tb_cpu_top
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
RUNFLAGS  ?= +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) $(RUNFLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q '\*\* PASS \*\*' $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- all.f
src/cpu_pkg.sv
src/icb_if.sv
src/aon_ctrl.sv
src/clk_ctrl.sv
src/icb_arbiter.sv
src/dtcm_ctrl.sv
src/cpu_top.sv
bench/cpu_top_assert.sv
bench/tb_cpu_top.sv

//--- bench/cpu_top_assert.sv
// CPU shell assertions
// Reset stretch, interrupt delay, DTCM latency, arbitration,
// back-pressure and light-sleep timing, bound into cpu_top
`timescale 1ns/100ps
`default_nettype none

module cpu_top_assert import cpu_pkg::*; (
  input logic  clk,
  input logic  reset,
  input logic  rst_core,
  input logic  rst_dtcm,
  input logic  dbg_irq_a,
  input logic  ext_irq_a,
  input logic  sft_irq_a,
  input logic  tmr_irq_a,
  input logic  dbg_irq_r,
  input logic  ext_irq_r,
  input logic  sft_irq_r,
  input logic  tmr_irq_r,
  input logic  lsu_cmd_valid,
  input logic  lsu_cmd_ready,
  input logic  lsu_rsp_valid,
  input logic  lsu_rsp_ready,
  input xlen_t lsu_rsp_rdata,
  input logic  ext_cmd_valid,
  input logic  ext_cmd_ready,
  input logic  ext_rsp_valid,
  input logic  ext_rsp_ready,
  input xlen_t ext_rsp_rdata,
  input logic  dtcm_ram_cs,
  input logic  dtcm_ls
);

  int fail_count = 0;

  ////////////////////
  // AON
  ////////////////////
  rst_stretch: assert property (@(posedge clk)
    $fell(reset) |-> (rst_core && rst_dtcm) ##1 (rst_core && rst_dtcm)
                     ##1 (rst_core && rst_dtcm) ##1 (!rst_core && !rst_dtcm))
    else begin
      fail_count++;
      $error("domain resets not stretched by two cycles");
    end

  irq_delay: assert property (@(posedge clk)
    (!reset && !$past(reset) && !$past(reset, 2)) |->
      ({dbg_irq_r, ext_irq_r, sft_irq_r, tmr_irq_r} ==
       $past({dbg_irq_a, ext_irq_a, sft_irq_a, tmr_irq_a}, 2)))
    else begin
      fail_count++;
      $error("irq outputs not two cycles behind inputs");
    end

  ////////////////////
  // DTCM path
  ////////////////////
  lsu_latency: assert property (@(posedge clk) disable iff (rst_dtcm)
    (lsu_cmd_valid && lsu_cmd_ready) |=> (lsu_rsp_valid && !ext_rsp_valid))
    else begin
      fail_count++;
      $error("LSU response missing or misrouted");
    end

  ext_latency: assert property (@(posedge clk) disable iff (rst_dtcm)
    (ext_cmd_valid && ext_cmd_ready) |=> (ext_rsp_valid && !lsu_rsp_valid))
    else begin
      fail_count++;
      $error("ext response missing or misrouted");
    end

  lsu_first: assert property (@(posedge clk) disable iff (rst_dtcm)
    (lsu_cmd_valid && ext_cmd_valid) |-> !ext_cmd_ready)
    else begin
      fail_count++;
      $error("ext granted while LSU requests");
    end

  lsu_stall: assert property (@(posedge clk) disable iff (rst_dtcm)
    (lsu_rsp_valid && !lsu_rsp_ready) |->
      (!lsu_cmd_ready && !ext_cmd_ready && !dtcm_ram_cs)
      ##1 (lsu_rsp_valid && $stable(lsu_rsp_rdata)))
    else begin
      fail_count++;
      $error("LSU back-pressure not honoured");
    end

  ext_stall: assert property (@(posedge clk) disable iff (rst_dtcm)
    (ext_rsp_valid && !ext_rsp_ready) |->
      (!lsu_cmd_ready && !ext_cmd_ready && !dtcm_ram_cs)
      ##1 (ext_rsp_valid && $stable(ext_rsp_rdata)))
    else begin
      fail_count++;
      $error("ext back-pressure not honoured");
    end

  // Light sleep one cycle after an idle cycle
  ls_timing: assert property (@(posedge clk) disable iff (reset)
    1'b1 |=> (dtcm_ls == !$past(lsu_cmd_valid || ext_cmd_valid ||
                                lsu_rsp_valid || ext_rsp_valid)))
    else begin
      fail_count++;
      $error("dtcm_ls does not follow DTCM idle");
    end

endmodule

bind cpu_top cpu_top_assert u_assert (.*);

`default_nettype wire

//--- bench/tb_cpu_top.sv
// CPU shell testbench
// Drives reset, interrupts, clock gating and both DTCM masters
// against an SRAM model and a shadow memory
`timescale 1ns/100ps
`default_nettype none

module tb_cpu_top import cpu_pkg::*; ();

  localparam int TIMEOUT = 50;
  localparam int NWORDS  = 1 << DTCM_RAM_AW;

  logic clk, reset;
  logic dbg_irq_a, ext_irq_a, sft_irq_a, tmr_irq_a;
  logic dbg_irq_r, ext_irq_r, sft_irq_r, tmr_irq_r;
  logic rst_core, rst_dtcm, core_active, cg_stop;
  logic clk_core, clk_dtcm_ram, dtcm_ls;
  logic lsu_cmd_valid, lsu_cmd_ready, lsu_cmd_read, lsu_rsp_valid, lsu_rsp_ready;
  logic ext_cmd_valid, ext_cmd_ready, ext_cmd_read, ext_rsp_valid, ext_rsp_ready;
  dtcm_addr_t lsu_cmd_addr, ext_cmd_addr;
  xlen_t lsu_cmd_wdata, ext_cmd_wdata, lsu_rsp_rdata, ext_rsp_rdata;
  wmask_t lsu_cmd_wmask, ext_cmd_wmask;
  logic dtcm_ram_cs, dtcm_ram_we;
  dtcm_ram_addr_t dtcm_ram_addr;
  wmask_t dtcm_ram_wem;
  xlen_t dtcm_ram_din;
  xlen_t dtcm_ram_dout = '0;

  xlen_t sram [NWORDS];
  xlen_t shadow [NWORDS];
  logic [31:0] lfsr = 32'hab13d7ab;
  int errors = 0;
  int timeouts = 0;
  int core_edges = 0;

  cpu_top dut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk_core) core_edges <= core_edges + 1;

  ////////////////////
  // SRAM model
  ////////////////////
  always @(posedge clk_dtcm_ram) begin
    if (dtcm_ram_cs) begin
      if (dtcm_ram_we) begin
        for (int b = 0; b < 4; b++) begin
          if (dtcm_ram_wem[b]) sram[dtcm_ram_addr][8*b +: 8] <= dtcm_ram_din[8*b +: 8];
        end
      end else begin
        dtcm_ram_dout <= sram[dtcm_ram_addr];  // Holds while cs low
      end
    end
  end

  ////////////////////
  // Helpers
  ////////////////////
  function automatic xlen_t fill_word(input dtcm_ram_addr_t a);
    return {a, 2'b10, ~a, 2'b01};
  endfunction

  function automatic xlen_t merge_bytes(input xlen_t old_w, input xlen_t new_w,
                                        input wmask_t m);
    xlen_t res;
    for (int b = 0; b < 4; b++) begin
      res[8*b +: 8] = m[b] ? new_w[8*b +: 8] : old_w[8*b +: 8];
    end
    return res;
  endfunction

  // Galois LFSR stepped once per bit taken
  function logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function logic rand_bit();
    logic [31:0] r;
    r = rand_bits(1);
    return r[0];
  endfunction

  task automatic check_data(input string name, input xlen_t got, input xlen_t exp);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s got %08h expected %08h", name, got, exp);
    end
  endtask

  task automatic set_cmd(input logic use_ext, input logic v, input logic rd,
                         input dtcm_addr_t a, input xlen_t wd, input wmask_t m);
    if (use_ext) begin
      ext_cmd_valid = v;
      ext_cmd_read  = rd;
      ext_cmd_addr  = a;
      ext_cmd_wdata = wd;
      ext_cmd_wmask = m;
    end else begin
      lsu_cmd_valid = v;
      lsu_cmd_read  = rd;
      lsu_cmd_addr  = a;
      lsu_cmd_wdata = wd;
      lsu_cmd_wmask = m;
    end
  endtask

  task automatic set_rsp_ready(input logic use_ext, input logic v);
    if (use_ext) ext_rsp_ready = v;
    else         lsu_rsp_ready = v;
  endtask

  // One ICB transfer from a falling edge with stall cycles of back-pressure
  task automatic icb_xfer(input logic use_ext, input logic rd, input dtcm_ram_addr_t wa,
                          input xlen_t wd, input wmask_t m, input int stall,
                          output xlen_t rdata);
    int cnt;
    logic hs;
    logic rv;
    hs = 1'b0;
    rv = 1'b0;
    cnt = 0;
    rdata = '0;
    set_rsp_ready(use_ext, 1'b1);
    set_cmd(use_ext, 1'b1, rd, {wa, 2'b00}, wd, m);
    while (!hs && cnt < TIMEOUT) begin
      #1 hs = use_ext ? ext_cmd_ready : lsu_cmd_ready;
      @(negedge clk);
      cnt++;
    end
    set_cmd(use_ext, 1'b0, 1'b0, '0, '0, '0);
    if (!hs) begin
      timeouts++;
      $display("Timed out waiting for cmd_ready on the %s port", use_ext ? "ext" : "lsu");
      return;
    end
    set_rsp_ready(use_ext, stall == 0);  // Stall starts with the response
    #1 rv = use_ext ? ext_rsp_valid : lsu_rsp_valid;
    if (!rv) begin
      errors++;
      $display("Response did not arrive one cycle after acceptance");
    end
    cnt = 0;
    while (!rv && cnt < TIMEOUT) begin
      @(negedge clk);
      #1 rv = use_ext ? ext_rsp_valid : lsu_rsp_valid;
      cnt++;
    end
    if (!rv) begin
      timeouts++;
      $display("Timed out waiting for rsp_valid");
    end
    rdata = use_ext ? ext_rsp_rdata : lsu_rsp_rdata;
    for (int s = 0; s < stall; s++) @(negedge clk);
    if (stall != 0) set_rsp_ready(use_ext, 1'b1);
    @(negedge clk);
  endtask

  task automatic write_word(input logic use_ext, input dtcm_ram_addr_t wa,
                            input xlen_t wd, input wmask_t m);
    xlen_t unused;
    icb_xfer(use_ext, 1'b0, wa, wd, m, 0, unused);
    shadow[wa] = merge_bytes(shadow[wa], wd, m);
  endtask

  task automatic read_check(input logic use_ext, input dtcm_ram_addr_t wa, input int stall);
    xlen_t got;
    icb_xfer(use_ext, 1'b1, wa, '0, '0, stall, got);
    check_data(use_ext ? "ext_rsp_rdata" : "lsu_rsp_rdata", got, shadow[wa]);
  endtask

  ////////////////////
  // Stimulus
  ////////////////////
  initial begin
    int cnt;
    int start;
    logic [31:0] r;
    dtcm_ram_addr_t wa;
    dtcm_ram_addr_t wb;
    xlen_t wd;
    wmask_t m;
    logic port;
    reset = 1'b1;
    {dbg_irq_a, ext_irq_a, sft_irq_a, tmr_irq_a} = '0;
    core_active = 1'b0;
    cg_stop = 1'b0;
    lsu_rsp_ready = 1'b1;
    ext_rsp_ready = 1'b1;
    set_cmd(1'b0, 1'b0, 1'b0, '0, '0, '0);
    set_cmd(1'b1, 1'b0, 1'b0, '0, '0, '0);
    for (int i = 0; i < NWORDS; i++) begin
      sram[i] = fill_word(dtcm_ram_addr_t'(i));
      shadow[i] = fill_word(dtcm_ram_addr_t'(i));
    end

    repeat (3) @(negedge clk);
    reset = 1'b0;
    cnt = 0;
    while ((rst_core || rst_dtcm) && cnt < TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    if (rst_core || rst_dtcm) begin
      timeouts++;
      $display("Timed out waiting for the domain resets to release");
    end

    // Core clock stays gated when idle
    repeat (2) @(negedge clk);
    start = core_edges;
    repeat (8) @(negedge clk);
    if (core_edges != start) begin
      errors++;
      $display("clk_core toggled while gated off");
    end
    cg_stop = 1'b1;
    repeat (2) @(negedge clk);
    start = core_edges;
    repeat (8) @(negedge clk);
    if (core_edges == start) begin
      errors++;
      $display("clk_core stayed idle with cg_stop high");
    end
    cg_stop = 1'b0;

    // Interrupt synchronizers
    for (int i = 0; i < 40; i++) begin
      r = rand_bits(4);
      {dbg_irq_a, ext_irq_a, sft_irq_a, tmr_irq_a} = r[3:0];
      @(negedge clk);
    end
    {dbg_irq_a, ext_irq_a, sft_irq_a, tmr_irq_a} = '0;
    repeat (3) @(negedge clk);

    ////////////////////
    // Memory path
    ////////////////////
    for (int i = 0; i < 24; i++) begin
      port = rand_bit();
      r = rand_bits(14);
      wa = r[13:0];
      wd = rand_bits(32);
      r = rand_bits(4);
      m = r[3:0];
      read_check(port, wa, 0);
      write_word(port, wa, wd, m);
      r = rand_bits(2);
      read_check(rand_bit(), wa, int'(r[1:0]));
      if (rand_bit()) repeat (2) @(negedge clk);
    end

    // Both masters at once
    for (int i = 0; i < 8; i++) begin
      r = rand_bits(14);
      wa = r[13:0];
      wb = wa ^ 14'h0015;
      wd = rand_bits(32);
      fork
        write_word(1'b0, wa, wd, 4'hf);
        write_word(1'b1, wb, ~wd, 4'h5);
      join
      fork
        read_check(1'b0, wa, i % 3);
        read_check(1'b1, wb, 1);
      join
    end

    repeat (5) @(negedge clk);
    $display("errors=%0d timeouts=%0d assertion_failures=%0d",
             errors, timeouts, dut.u_assert.fail_count);
    if (errors == 0 && timeouts == 0 && dut.u_assert.fail_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src/aon_ctrl.sv
// Always-on control
// Stretches the incoming reset into the core and DTCM domain resets
// and synchronizes the four interrupt lines into the clk domain
`timescale 1ns/100ps
`default_nettype none

module aon_ctrl import cpu_pkg::*; (
  input  logic clk,
  input  logic reset,
  input  logic dbg_irq_a,
  input  logic ext_irq_a,
  input  logic sft_irq_a,
  input  logic tmr_irq_a,
  output logic rst_core,
  output logic rst_dtcm,
  output logic dbg_irq_r,
  output logic ext_irq_r,
  output logic sft_irq_r,
  output logic tmr_irq_r
);

  logic [RST_SYNC_LEVEL-1:0]      rst_chain;
  logic [3:0]                     irq_a;     // dbg, ext, sft, tmr
  logic [3:0]                     irq_meta;
  logic [IRQ_SYNC_LEVEL-2:0][3:0] irq_sync;

  ////////////////////
  // Reset stretch
  ////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      rst_chain <= '1;
      rst_core  <= 1'b1;
      rst_dtcm  <= 1'b1;
    end else begin
      rst_chain <= rst_chain << 1;          // Zeros walk towards the top
      rst_core  <= rst_chain[RST_SYNC_LEVEL-1];
      rst_dtcm  <= rst_chain[RST_SYNC_LEVEL-1]; // Own flop per domain
    end
  end

  assign irq_a = {dbg_irq_a, ext_irq_a, sft_irq_a, tmr_irq_a};

  ////////////////////
  // IRQ stage 1
  ////////////////////
  // May go metastable, never read outside this block
  always_ff @(posedge clk) begin
    if (reset) irq_meta <= '0;
    else       irq_meta <= irq_a;
  end

  ////////////////////
  // IRQ stage 2
  ////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      irq_sync <= '0;
    end else begin
      irq_sync[0] <= irq_meta;
      for (int i = 1; i < IRQ_SYNC_LEVEL - 1; i++) begin
        irq_sync[i] <= irq_sync[i-1];       // Extra stages if ever deepened
      end
    end
  end

  assign {dbg_irq_r, ext_irq_r, sft_irq_r, tmr_irq_r} = irq_sync[IRQ_SYNC_LEVEL-2];

endmodule

`default_nettype wire

//--- src/clk_ctrl.sv
// Clock control
// Gates the core and DTCM clocks and drives the DTCM light-sleep level
`timescale 1ns/100ps
`default_nettype none

module clk_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic rst_core,
  input  logic rst_dtcm,
  input  logic core_active,
  input  logic dtcm_active,
  input  logic cg_stop,
  output logic clk_core,
  output logic clk_dtcm,
  output logic dtcm_ls
);

  logic [1:0] gate_en;    // Bit 0 core, bit 1 DTCM
  logic [1:0] gate_en_q;
  logic [1:0] gated_clk;

  ////////////////////
  // Clock gates
  ////////////////////
  // Domains keep running while held in reset so their sync resets land
  assign gate_en[0] = core_active | cg_stop | rst_core;
  assign gate_en[1] = dtcm_active | cg_stop | rst_dtcm;

  // Enable latch is open only in the low phase
  // so the gated clock cannot glitch while clk is high
  always_latch begin
    if (!clk) begin
      gate_en_q <= gate_en;
    end
  end

  assign gated_clk = {2{clk}} & gate_en_q;

  assign clk_core = gated_clk[0];
  assign clk_dtcm = gated_clk[1];

  ////////////////////
  // Light sleep
  ////////////////////
  // SRAM may sleep the cycle after the DTCM saw no traffic
  always_ff @(posedge clk) begin
    if (reset) begin
      dtcm_ls <= 1'b0;
    end else begin
      dtcm_ls <= ~dtcm_active;
    end
  end

endmodule

`default_nettype wire

//--- src/cpu_pkg.sv
// CPU shell shared definitions
// Widths and types for the always-on glue and the DTCM path
`default_nettype none

package cpu_pkg;

  ////////////////////
  // Widths
  ////////////////////
  localparam int XLEN            = 32;
  localparam int DTCM_ADDR_WIDTH = 16;                  // Byte address of the DTCM region
  localparam int DTCM_RAM_AW     = DTCM_ADDR_WIDTH - 2; // SRAM word address

  // Synchronizer depths
  localparam int RST_SYNC_LEVEL = 2;
  localparam int IRQ_SYNC_LEVEL = 2;

  ////////////////////
  // Types
  ////////////////////
  typedef logic [XLEN-1:0]            xlen_t;
  typedef logic [XLEN/8-1:0]          wmask_t;          // One bit per byte lane
  typedef logic [DTCM_ADDR_WIDTH-1:0] dtcm_addr_t;
  typedef logic [DTCM_RAM_AW-1:0]     dtcm_ram_addr_t;

  // Master that owns the response in flight
  typedef enum logic {
    OWNER_LSU,
    OWNER_EXT
  } icb_owner_e;

endpackage

`default_nettype wire

//--- src/cpu_top.sv
// CPU shell top level
// Always-on reset and interrupt glue, clock gating and the DTCM path
// shared by the LSU and an external agent
`timescale 1ns/100ps
`default_nettype none

module cpu_top import cpu_pkg::*; (
  input  logic           clk,
  input  logic           reset,
  // Interrupts
  input  logic           dbg_irq_a,
  input  logic           ext_irq_a,
  input  logic           sft_irq_a,
  input  logic           tmr_irq_a,
  output logic           dbg_irq_r,
  output logic           ext_irq_r,
  output logic           sft_irq_r,
  output logic           tmr_irq_r,
  // Resets and clocks
  output logic           rst_core,
  output logic           rst_dtcm,
  input  logic           core_active,
  input  logic           cg_stop,
  output logic           clk_core,
  output logic           clk_dtcm_ram,
  output logic           dtcm_ls,
  // LSU to DTCM
  input  logic           lsu_cmd_valid,
  output logic           lsu_cmd_ready,
  input  dtcm_addr_t     lsu_cmd_addr,
  input  logic           lsu_cmd_read,
  input  xlen_t          lsu_cmd_wdata,
  input  wmask_t         lsu_cmd_wmask,
  output logic           lsu_rsp_valid,
  input  logic           lsu_rsp_ready,
  output xlen_t          lsu_rsp_rdata,
  // External agent to DTCM
  input  logic           ext_cmd_valid,
  output logic           ext_cmd_ready,
  input  dtcm_addr_t     ext_cmd_addr,
  input  logic           ext_cmd_read,
  input  xlen_t          ext_cmd_wdata,
  input  wmask_t         ext_cmd_wmask,
  output logic           ext_rsp_valid,
  input  logic           ext_rsp_ready,
  output xlen_t          ext_rsp_rdata,
  // DTCM SRAM
  output logic           dtcm_ram_cs,
  output logic           dtcm_ram_we,
  output dtcm_ram_addr_t dtcm_ram_addr,
  output wmask_t         dtcm_ram_wem,
  output xlen_t          dtcm_ram_din,
  input  xlen_t          dtcm_ram_dout
);

  logic clk_dtcm;
  logic dtcm_active;

  icb_if arb2dtcm ();

  ////////////////////
  // Always-on domain
  ////////////////////
  aon_ctrl u_aon_ctrl (
    .clk       (clk),
    .reset     (reset),
    .dbg_irq_a (dbg_irq_a),
    .ext_irq_a (ext_irq_a),
    .sft_irq_a (sft_irq_a),
    .tmr_irq_a (tmr_irq_a),
    .rst_core  (rst_core),
    .rst_dtcm  (rst_dtcm),
    .dbg_irq_r (dbg_irq_r),
    .ext_irq_r (ext_irq_r),
    .sft_irq_r (sft_irq_r),
    .tmr_irq_r (tmr_irq_r)
  );

  clk_ctrl u_clk_ctrl (
    .clk         (clk),
    .reset       (reset),
    .rst_core    (rst_core),
    .rst_dtcm    (rst_dtcm),
    .core_active (core_active),
    .dtcm_active (dtcm_active),
    .cg_stop     (cg_stop),
    .clk_core    (clk_core),
    .clk_dtcm    (clk_dtcm),
    .dtcm_ls     (dtcm_ls)
  );

  assign clk_dtcm_ram = clk_dtcm;  // SRAM shares the DTCM gated clock

  ////////////////////
  // DTCM domain
  ////////////////////
  icb_arbiter u_icb_arbiter (
    .clk_dtcm      (clk_dtcm),
    .rst_dtcm      (rst_dtcm),
    .lsu_cmd_valid (lsu_cmd_valid),
    .lsu_cmd_ready (lsu_cmd_ready),
    .lsu_cmd_addr  (lsu_cmd_addr),
    .lsu_cmd_read  (lsu_cmd_read),
    .lsu_cmd_wdata (lsu_cmd_wdata),
    .lsu_cmd_wmask (lsu_cmd_wmask),
    .lsu_rsp_valid (lsu_rsp_valid),
    .lsu_rsp_ready (lsu_rsp_ready),
    .lsu_rsp_rdata (lsu_rsp_rdata),
    .ext_cmd_valid (ext_cmd_valid),
    .ext_cmd_ready (ext_cmd_ready),
    .ext_cmd_addr  (ext_cmd_addr),
    .ext_cmd_read  (ext_cmd_read),
    .ext_cmd_wdata (ext_cmd_wdata),
    .ext_cmd_wmask (ext_cmd_wmask),
    .ext_rsp_valid (ext_rsp_valid),
    .ext_rsp_ready (ext_rsp_ready),
    .ext_rsp_rdata (ext_rsp_rdata),
    .dtcm          (arb2dtcm.master),
    .dtcm_active   (dtcm_active)
  );

  dtcm_ctrl u_dtcm_ctrl (
    .clk_dtcm      (clk_dtcm),
    .rst_dtcm      (rst_dtcm),
    .icb           (arb2dtcm.slave),
    .dtcm_ram_cs   (dtcm_ram_cs),
    .dtcm_ram_we   (dtcm_ram_we),
    .dtcm_ram_addr (dtcm_ram_addr),
    .dtcm_ram_wem  (dtcm_ram_wem),
    .dtcm_ram_din  (dtcm_ram_din),
    .dtcm_ram_dout (dtcm_ram_dout)
  );

endmodule

`default_nettype wire

//--- src/dtcm_ctrl.sv
// DTCM controller
// Turns ICB commands into single-port SRAM strobes and returns the
// read data one cycle after acceptance
`timescale 1ns/100ps
`default_nettype none

module dtcm_ctrl import cpu_pkg::*; (
  input  logic           clk_dtcm,
  input  logic           rst_dtcm,
  icb_if.slave           icb,
  // SRAM side
  output logic           dtcm_ram_cs,
  output logic           dtcm_ram_we,
  output dtcm_ram_addr_t dtcm_ram_addr,
  output wmask_t         dtcm_ram_wem,
  output xlen_t          dtcm_ram_din,
  input  xlen_t          dtcm_ram_dout
);

  logic rsp_pend;  // Response owed to the bus
  logic cmd_hsk;
  logic rsp_hsk;

  ////////////////////
  // Handshakes
  ////////////////////
  // A new command only when the previous response leaves this cycle
  assign icb.cmd_ready = ~rsp_pend | icb.rsp_ready;

  assign cmd_hsk = icb.cmd_valid & icb.cmd_ready;
  assign rsp_hsk = rsp_pend & icb.rsp_ready;

  always_ff @(posedge clk_dtcm) begin
    if (rst_dtcm) begin
      rsp_pend <= 1'b0;
    end else if (cmd_hsk) begin
      rsp_pend <= 1'b1;   // Back to back keeps it set
    end else if (rsp_hsk) begin
      rsp_pend <= 1'b0;
    end
  end

  assign icb.rsp_valid = rsp_pend;

  // SRAM output register holds while cs stays low
  assign icb.rsp_rdata = dtcm_ram_dout;

  ////////////////////
  // SRAM strobes
  ////////////////////
  assign dtcm_ram_cs   = cmd_hsk;
  assign dtcm_ram_we   = ~icb.cmd_read;
  assign dtcm_ram_addr = icb.cmd_addr[DTCM_ADDR_WIDTH-1:2]; // Word address
  assign dtcm_ram_wem  = icb.cmd_wmask;
  assign dtcm_ram_din  = icb.cmd_wdata;

endmodule

`default_nettype wire

//--- src/icb_arbiter.sv
// DTCM ICB arbiter
// Fixed priority between the LSU and the external port, LSU first,
// with the response steered back to the master that issued the command
`timescale 1ns/100ps
`default_nettype none

module icb_arbiter import cpu_pkg::*; (
  input  logic       clk_dtcm,
  input  logic       rst_dtcm,
  // LSU port
  input  logic       lsu_cmd_valid,
  output logic       lsu_cmd_ready,
  input  dtcm_addr_t lsu_cmd_addr,
  input  logic       lsu_cmd_read,
  input  xlen_t      lsu_cmd_wdata,
  input  wmask_t     lsu_cmd_wmask,
  output logic       lsu_rsp_valid,
  input  logic       lsu_rsp_ready,
  output xlen_t      lsu_rsp_rdata,
  // External agent port
  input  logic       ext_cmd_valid,
  output logic       ext_cmd_ready,
  input  dtcm_addr_t ext_cmd_addr,
  input  logic       ext_cmd_read,
  input  xlen_t      ext_cmd_wdata,
  input  wmask_t     ext_cmd_wmask,
  output logic       ext_rsp_valid,
  input  logic       ext_rsp_ready,
  output xlen_t      ext_rsp_rdata,
  // Towards the DTCM controller
  icb_if.master      dtcm,
  output logic       dtcm_active
);

  icb_owner_e rsp_owner;   // Who gets the response in flight
  logic       cmd_hsk;

  ////////////////////
  // Command select
  ////////////////////
  assign dtcm.cmd_valid = lsu_cmd_valid | ext_cmd_valid;
  assign dtcm.cmd_addr  = lsu_cmd_valid ? lsu_cmd_addr  : ext_cmd_addr;
  assign dtcm.cmd_read  = lsu_cmd_valid ? lsu_cmd_read  : ext_cmd_read;
  assign dtcm.cmd_wdata = lsu_cmd_valid ? lsu_cmd_wdata : ext_cmd_wdata;
  assign dtcm.cmd_wmask = lsu_cmd_valid ? lsu_cmd_wmask : ext_cmd_wmask;

  assign lsu_cmd_ready = dtcm.cmd_ready;
  assign ext_cmd_ready = dtcm.cmd_ready & ~lsu_cmd_valid; // Loses to LSU

  assign cmd_hsk = dtcm.cmd_valid & dtcm.cmd_ready;

  always_ff @(posedge clk_dtcm) begin
    if (rst_dtcm) begin
      rsp_owner <= OWNER_LSU;
    end else if (cmd_hsk) begin
      rsp_owner <= lsu_cmd_valid ? OWNER_LSU : OWNER_EXT;
    end
  end

  ////////////////////
  // Response route
  ////////////////////
  assign lsu_rsp_valid  = dtcm.rsp_valid & (rsp_owner == OWNER_LSU);
  assign ext_rsp_valid  = dtcm.rsp_valid & (rsp_owner == OWNER_EXT);
  assign lsu_rsp_rdata  = dtcm.rsp_rdata;   // Qualified by valid
  assign ext_rsp_rdata  = dtcm.rsp_rdata;
  assign dtcm.rsp_ready = (rsp_owner == OWNER_LSU) ? lsu_rsp_ready : ext_rsp_ready;

  // Keeps clk_dtcm running while anything is requested or still owed
  assign dtcm_active = lsu_cmd_valid | ext_cmd_valid | dtcm.rsp_valid;

endmodule

`default_nettype wire

//--- src/icb_if.sv
// ICB bus between the arbiter and the DTCM controller
// Command channel plus a single response channel
`timescale 1ns/100ps
`default_nettype none

interface icb_if import cpu_pkg::*; ();

  // Command channel
  logic       cmd_valid;
  logic       cmd_ready;
  dtcm_addr_t cmd_addr;
  logic       cmd_read;    // High for read, low for write
  xlen_t      cmd_wdata;
  wmask_t     cmd_wmask;

  // Response channel
  logic       rsp_valid;
  logic       rsp_ready;
  xlen_t      rsp_rdata;

  modport master (
    output cmd_valid, cmd_addr, cmd_read, cmd_wdata, cmd_wmask, rsp_ready,
    input  cmd_ready, rsp_valid, rsp_rdata
  );

  modport slave (
    input  cmd_valid, cmd_addr, cmd_read, cmd_wdata, cmd_wmask, rsp_ready,
    output cmd_ready, rsp_valid, rsp_rdata
  );

endinterface

`default_nettype wire
